// ==== logic/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        opRType    = 6'b000000,
        opRegImm   = 6'b000001,   // bgez / bltz, picked by rt
        opJ        = 6'b000010,
        opBeq      = 6'b000100,
        opBne      = 6'b000101,
        opBlez     = 6'b000110,
        opBgtz     = 6'b000111,
        opAddi     = 6'b001000,
        opAddiu    = 6'b001001,
        opSlti     = 6'b001010,
        opSltiu    = 6'b001011,
        opAndi     = 6'b001100,
        opOri      = 6'b001101,
        opXori     = 6'b001110,
        opLui      = 6'b001111,
        opSpecial3 = 6'b011111,   // seb / seh, picked by sa
        opLb       = 6'b100000,
        opLh       = 6'b100001,
        opLw       = 6'b100011,
        opSb       = 6'b101000,
        opSh       = 6'b101001,
        opSw       = 6'b101011
    } opcodeE;

    // R-format function field, instr[5:0]
    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,   // rotr when bit 21 set
        fnSllv = 6'b000100,
        fnSrlv = 6'b000110,   // rotrv when bit 6 set
        fnAdd  = 6'b100000,
        fnAddu = 6'b100001,
        fnSub  = 6'b100010,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnNor  = 6'b100111,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } functE;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluRotr, aluLui,
        aluSeb, aluSeh,
        aluBeq, aluBne, aluBgez, aluBltz, aluBgtz, aluBlez
    } aluOpE;

    // access width for loads and stores
    typedef enum logic [1:0] {
        dtWord = 2'd0,
        dtHalf = 2'd1,
        dtByte = 2'd2
    } dataTypeE;

endpackage

`default_nettype wire

// ==== logic/controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module controller (
    input  logic [31:0]       instr,
    output logic              regWrite,
    output logic              memRead,
    output logic              memWrite,
    output logic              memToReg,
    output logic              branch,
    output logic              jump,
    output logic              signExtend,
    output logic              aluSrc1,    // shift amount from sa field
    output logic              aluSrc2,    // immediate instead of rt
    output logic [4:0]        wbReg,
    output mipsPkg::dataTypeE dataType,
    output mipsPkg::aluOpE    aluOp
);

    logic regDst;   // write rd instead of rt

    always_comb begin
        // everything inactive unless the opcode says otherwise
        regDst     = 1'b0;
        regWrite   = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        memToReg   = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        signExtend = 1'b0;
        aluSrc1    = 1'b0;
        aluSrc2    = 1'b0;
        dataType   = mipsPkg::dtWord;
        aluOp      = mipsPkg::aluAdd;

        case (instr[31:26])
            mipsPkg::opRType: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
                case (instr[5:0])
                    mipsPkg::fnAdd, mipsPkg::fnAddu: aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSub:  aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   aluOp = mipsPkg::aluOr;
                    mipsPkg::fnXor:  aluOp = mipsPkg::aluXor;
                    mipsPkg::fnNor:  aluOp = mipsPkg::aluNor;
                    mipsPkg::fnSlt:  aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnSltu: aluOp = mipsPkg::aluSltu;
                    mipsPkg::fnSll: begin
                        aluSrc1 = 1'b1;
                        aluOp   = mipsPkg::aluSll;
                    end
                    mipsPkg::fnSrl: begin
                        aluSrc1 = 1'b1;
                        aluOp   = instr[21] ? mipsPkg::aluRotr : mipsPkg::aluSrl;
                    end
                    mipsPkg::fnSllv: aluOp = mipsPkg::aluSll;   // amount from rs
                    mipsPkg::fnSrlv: aluOp = instr[6] ? mipsPkg::aluRotr : mipsPkg::aluSrl;
                    default: begin
                        regDst   = 1'b0;
                        regWrite = 1'b0;
                    end
                endcase
            end

            mipsPkg::opSpecial3: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
                case (instr[10:6])
                    5'b10000: aluOp = mipsPkg::aluSeb;
                    5'b11000: aluOp = mipsPkg::aluSeh;
                    default: begin
                        regDst   = 1'b0;
                        regWrite = 1'b0;
                    end
                endcase
            end

            mipsPkg::opRegImm: begin
                branch = 1'b1;
                case (instr[20:16])
                    5'b00001: aluOp = mipsPkg::aluBgez;
                    5'b00000: aluOp = mipsPkg::aluBltz;
                    default:  branch = 1'b0;
                endcase
            end

            mipsPkg::opBeq: begin
                branch = 1'b1;
                aluOp  = mipsPkg::aluBeq;
            end
            mipsPkg::opBne: begin
                branch = 1'b1;
                aluOp  = mipsPkg::aluBne;
            end
            mipsPkg::opBgtz: begin
                branch = 1'b1;
                aluOp  = mipsPkg::aluBgtz;
            end
            mipsPkg::opBlez: begin
                branch = 1'b1;
                aluOp  = mipsPkg::aluBlez;
            end
            mipsPkg::opJ: jump = 1'b1;

            // immediate arithmetic and logic, result to rt
            mipsPkg::opAddi, mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu,
            mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui: begin
                regWrite = 1'b1;
                aluSrc2  = 1'b1;
                case (instr[31:26])
                    mipsPkg::opSlti:  aluOp = mipsPkg::aluSlt;
                    mipsPkg::opSltiu: aluOp = mipsPkg::aluSltu;   // imm still sign extended
                    mipsPkg::opAndi:  aluOp = mipsPkg::aluAnd;
                    mipsPkg::opOri:   aluOp = mipsPkg::aluOr;
                    mipsPkg::opXori:  aluOp = mipsPkg::aluXor;
                    mipsPkg::opLui:   aluOp = mipsPkg::aluLui;
                    default:          aluOp = mipsPkg::aluAdd;
                endcase
                signExtend = (instr[28:26] <= 3'b011);   // addi, addiu, slti, sltiu
            end

            mipsPkg::opLw, mipsPkg::opLh, mipsPkg::opLb: begin
                regWrite   = 1'b1;
                memRead    = 1'b1;
                memToReg   = 1'b1;
                aluSrc2    = 1'b1;
                signExtend = 1'b1;   // offset and lh/lb data
                dataType   = (instr[27:26] == 2'b11) ? mipsPkg::dtWord :
                             instr[26] ? mipsPkg::dtHalf : mipsPkg::dtByte;
            end

            mipsPkg::opSw, mipsPkg::opSh, mipsPkg::opSb: begin
                memWrite   = 1'b1;
                aluSrc2    = 1'b1;
                signExtend = 1'b1;
                dataType   = (instr[27:26] == 2'b11) ? mipsPkg::dtWord :
                             instr[26] ? mipsPkg::dtHalf : mipsPkg::dtByte;
            end

            default: ;   // unknown encoding, all inactive
        endcase
    end

    assign wbReg = regDst ? instr[15:11] : instr[20:16];

endmodule

`default_nettype wire

// ==== logic/aluUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
    input  logic [31:0]    instr,
    input  logic [31:0]    rsData,
    input  logic [31:0]    rtData,
    input  logic           aluSrc1,
    input  logic           aluSrc2,
    input  logic           signExtend,
    input  logic           branch,
    input  mipsPkg::aluOpE aluOp,
    output logic [31:0]    result,
    output logic           branchTaken
);

    logic [31:0] immExt;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [4:0]  shamt;
    logic        cond;

    assign immExt = signExtend ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};
    assign opA    = aluSrc1 ? {27'b0, instr[10:6]} : rsData;
    assign opB    = aluSrc2 ? immExt : rtData;
    assign shamt  = opA[4:0];   // sa field or rs low bits

    always_comb begin
        result = 32'b0;
        cond   = 1'b0;
        case (aluOp)
            mipsPkg::aluAdd:  result = opA + opB;
            mipsPkg::aluSub:  result = opA - opB;
            mipsPkg::aluAnd:  result = opA & opB;
            mipsPkg::aluOr:   result = opA | opB;
            mipsPkg::aluXor:  result = opA ^ opB;
            mipsPkg::aluNor:  result = ~(opA | opB);
            mipsPkg::aluSlt:  result = {31'b0, $signed(opA) < $signed(opB)};
            mipsPkg::aluSltu: result = {31'b0, opA < opB};
            mipsPkg::aluSll:  result = opB << shamt;
            mipsPkg::aluSrl:  result = opB >> shamt;
            // shift by 32 yields zero, so sa of 0 falls out right
            mipsPkg::aluRotr: result = (opB >> shamt) | (opB << (6'd32 - {1'b0, shamt}));
            mipsPkg::aluLui:  result = {opB[15:0], 16'b0};
            mipsPkg::aluSeb:  result = {{24{opB[7]}}, opB[7:0]};
            mipsPkg::aluSeh:  result = {{16{opB[15]}}, opB[15:0]};
            mipsPkg::aluBeq:  cond = (opA == opB);
            mipsPkg::aluBne:  cond = (opA != opB);
            mipsPkg::aluBgez: cond = ~opA[31];
            mipsPkg::aluBltz: cond = opA[31];
            mipsPkg::aluBgtz: cond = ~opA[31] && (opA != 32'b0);
            mipsPkg::aluBlez: cond = opA[31] || (opA == 32'b0);
            default: ;
        endcase
    end

    assign branchTaken = branch & cond;

endmodule

`default_nettype wire

// ==== logic/registerFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module registerFile (
    input  logic        Clk,
    input  logic        rst,
    input  logic        regWrite,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  logic [4:0]  wbReg,
    input  logic [31:0] wbData,
    output logic [31:0] rsData,
    output logic [31:0] rtData
);

    logic [31:0] regs [32];

    // $zero always reads back as zero
    assign rsData = (rsAddr == 5'd0) ? 32'b0 : regs[rsAddr];
    assign rtData = (rtAddr == 5'd0) ? 32'b0 : regs[rtAddr];

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (regWrite && (wbReg != 5'd0)) begin
            regs[wbReg] <= wbData;
        end
    end

endmodule

`default_nettype wire

// ==== logic/memAccess.sv ====
`timescale 1ns/10ps
`default_nettype none

module memAccess (
    input  logic [31:0]       aluResult,
    input  logic [31:0]       rtData,
    input  logic [31:0]       memReadData,
    input  mipsPkg::dataTypeE dataType,
    input  logic              signExtend,
    input  logic              memToReg,
    input  logic              memWrite,
    output logic [3:0]        memByteEn,
    output logic [31:0]       memWriteData,
    output logic [31:0]       wbData
);

    logic [3:0]  laneEn;
    logic [31:0] shifted;   // addressed byte moved to bits 7:0
    logic [15:0] halfLane;
    logic [31:0] loadVal;

    assign shifted  = memReadData >> {aluResult[1:0], 3'b000};
    assign halfLane = aluResult[1] ? memReadData[31:16] : memReadData[15:0];

    always_comb begin
        case (dataType)
            mipsPkg::dtHalf: begin
                laneEn       = aluResult[1] ? 4'b1100 : 4'b0011;
                memWriteData = {2{rtData[15:0]}};
                loadVal      = {{16{signExtend & halfLane[15]}}, halfLane};
            end
            mipsPkg::dtByte: begin
                laneEn       = 4'b0001 << aluResult[1:0];
                memWriteData = {4{rtData[7:0]}};   // every lane carries the byte
                loadVal      = {{24{signExtend & shifted[7]}}, shifted[7:0]};
            end
            default: begin
                laneEn       = 4'b1111;
                memWriteData = rtData;
                loadVal      = memReadData;
            end
        endcase
    end

    assign memByteEn = memWrite ? laneEn : 4'b0000;
    assign wbData    = memToReg ? loadVal : aluResult;

endmodule

`default_nettype wire

// ==== logic/executeCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module executeCore (
    input  logic        Clk,
    input  logic        rst,
    input  logic [31:0] instr,
    input  logic [31:0] memReadData,
    output logic [31:0] memAddr,
    output logic [31:0] memWriteData,
    output logic [3:0]  memByteEn,
    output logic        memRead,
    output logic        memWrite,
    output logic        regWrite,
    output logic [4:0]  wbReg,
    output logic [31:0] wbData,
    output logic        branchTaken,
    output logic        jump
);

    logic              memToReg;
    logic              branch;
    logic              signExtend;
    logic              aluSrc1;
    logic              aluSrc2;
    mipsPkg::dataTypeE dataType;
    mipsPkg::aluOpE    aluOp;
    logic [31:0]       rsData;
    logic [31:0]       rtData;

    controller ctrl (
        .instr      (instr),
        .regWrite   (regWrite),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .memToReg   (memToReg),
        .branch     (branch),
        .jump       (jump),
        .signExtend (signExtend),
        .aluSrc1    (aluSrc1),
        .aluSrc2    (aluSrc2),
        .wbReg      (wbReg),
        .dataType   (dataType),
        .aluOp      (aluOp)
    );

    registerFile regFile (
        .Clk      (Clk),
        .rst      (rst),
        .regWrite (regWrite),
        .rsAddr   (instr[25:21]),
        .rtAddr   (instr[20:16]),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .rsData   (rsData),
        .rtData   (rtData)
    );

    aluUnit alu (
        .instr       (instr),
        .rsData      (rsData),
        .rtData      (rtData),
        .aluSrc1     (aluSrc1),
        .aluSrc2     (aluSrc2),
        .signExtend  (signExtend),
        .branch      (branch),
        .aluOp       (aluOp),
        .result      (memAddr),   // ALU result doubles as the address
        .branchTaken (branchTaken)
    );

    memAccess memUnit (
        .aluResult    (memAddr),
        .rtData       (rtData),
        .memReadData  (memReadData),
        .dataType     (dataType),
        .signExtend   (signExtend),
        .memToReg     (memToReg),
        .memWrite     (memWrite),
        .memByteEn    (memByteEn),
        .memWriteData (memWriteData),
        .wbData       (wbData)
    );

endmodule

`default_nettype wire

// ==== tests/executeCoreChecker.sv ====
`timescale 1ns/10ps
`default_nettype none

module executeCoreChecker (
    input  logic        Clk,
    input  logic        active,        // high while a table row is applied
    input  logic [31:0] instr,
    input  logic [31:0] memAddr,
    input  logic [31:0] memWriteData,
    input  logic [3:0]  memByteEn,
    input  logic        memRead,
    input  logic        memWrite,
    input  logic        regWrite,
    input  logic [4:0]  wbReg,
    input  logic [31:0] wbData,
    input  logic        branchTaken,
    input  logic        jump,
    input  logic        expBranch,
    input  logic        expJump,
    output int          errorCount,
    output int          checkCount
);

    logic [31:0] regs [32];      // architectural register model
    logic [31:0] memCopy [64];   // loaded by the testbench before reset ends
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] zx;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] val;
    logic [31:0] wd;
    logic [15:0] half;
    logic [7:0]  byt;
    logic [4:0]  dst;
    logic [3:0]  be;
    logic        we;
    logic        isLoad;
    logic        isStore;

    initial begin
        errorCount = 0;
        checkCount = 0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'b0;
        end
    end

    function automatic logic [31:0] rotateRight(input logic [31:0] v, input logic [4:0] n);
        for (int i = 0; i < n; i++) begin
            v = {v[0], v[31:1]};   // one bit at a time
        end
        return v;
    endfunction

    task automatic compareValue(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED %0t: %s is %h, expected %h (instr %h)",
                     $time, what, got, exp, instr);
        end
    endtask

    always @(posedge Clk) begin
        if (active) begin
            a       = regs[instr[25:21]];
            b       = regs[instr[20:16]];
            sx      = {{16{instr[15]}}, instr[15:0]};
            zx      = {16'b0, instr[15:0]};
            addr    = a + sx;   // effective address for loads and stores
            word    = memCopy[addr[7:2]];
            half    = addr[1] ? word[31:16] : word[15:0];
            byt     = word[8*addr[1:0] +: 8];
            we      = 1'b0;
            isLoad  = 1'b0;
            isStore = 1'b0;
            dst     = instr[20:16];
            val     = 32'b0;
            be      = 4'b0000;
            wd      = 32'b0;

            case (instr[31:26])
                mipsPkg::opRType: begin
                    we  = 1'b1;
                    dst = instr[15:11];
                    case (instr[5:0])
                        mipsPkg::fnAdd, mipsPkg::fnAddu: val = a + b;
                        mipsPkg::fnSub:  val = a - b;
                        mipsPkg::fnAnd:  val = a & b;
                        mipsPkg::fnOr:   val = a | b;
                        mipsPkg::fnXor:  val = a ^ b;
                        mipsPkg::fnNor:  val = ~(a | b);
                        mipsPkg::fnSlt:  val = {31'b0, $signed(a) < $signed(b)};
                        mipsPkg::fnSltu: val = {31'b0, a < b};
                        mipsPkg::fnSll:  val = b << instr[10:6];
                        mipsPkg::fnSrl:  val = instr[21] ? rotateRight(b, instr[10:6])
                                                         : b >> instr[10:6];
                        mipsPkg::fnSllv: val = b << a[4:0];
                        mipsPkg::fnSrlv: val = instr[6] ? rotateRight(b, a[4:0]) : b >> a[4:0];
                        default:         we = 1'b0;
                    endcase
                end
                mipsPkg::opSpecial3: begin
                    we  = (instr[10:6] == 5'b10000) || (instr[10:6] == 5'b11000);
                    dst = instr[15:11];
                    // seh has sa bit 3 set
                    val = instr[9] ? {{16{b[15]}}, b[15:0]} : {{24{b[7]}}, b[7:0]};
                end
                mipsPkg::opAddi, mipsPkg::opAddiu: val = a + sx;
                mipsPkg::opSlti:  val = {31'b0, $signed(a) < $signed(sx)};
                mipsPkg::opSltiu: val = {31'b0, a < sx};
                mipsPkg::opAndi:  val = a & zx;
                mipsPkg::opOri:   val = a | zx;
                mipsPkg::opXori:  val = a ^ zx;
                mipsPkg::opLui:   val = {instr[15:0], 16'b0};
                mipsPkg::opLw: begin
                    isLoad = 1'b1;
                    val    = word;
                end
                mipsPkg::opLh: begin
                    isLoad = 1'b1;
                    val    = {{16{half[15]}}, half};
                end
                mipsPkg::opLb: begin
                    isLoad = 1'b1;
                    val    = {{24{byt[7]}}, byt};
                end
                mipsPkg::opSw: begin
                    isStore = 1'b1;
                    be      = 4'b1111;
                    wd      = b;
                end
                mipsPkg::opSh: begin
                    isStore = 1'b1;
                    be      = addr[1] ? 4'b1100 : 4'b0011;
                    wd      = {b[15:0], b[15:0]};
                end
                mipsPkg::opSb: begin
                    isStore = 1'b1;
                    be      = 4'b0001 << addr[1:0];
                    wd      = {4{b[7:0]}};
                end
                default: ;   // branches, jump, unknown: nothing written
            endcase
            we = we | isLoad | (instr[31:29] == 3'b001);   // 001xxx is the imm ALU group

            compareValue("regWrite", {31'b0, regWrite}, {31'b0, we});
            if (we) begin
                compareValue("wbReg", {27'b0, wbReg}, {27'b0, dst});
                compareValue("wbData", wbData, val);
            end
            compareValue("memRead", {31'b0, memRead}, {31'b0, isLoad});
            compareValue("memWrite", {31'b0, memWrite}, {31'b0, isStore});
            if (isLoad || isStore) begin
                compareValue("memAddr", memAddr, addr);
            end
            compareValue("memByteEn", {28'b0, memByteEn}, {28'b0, be});   // zero unless a store
            if (isStore) begin
                compareValue("memWriteData", memWriteData, wd);
            end
            compareValue("branchTaken", {31'b0, branchTaken}, {31'b0, expBranch});
            compareValue("jump", {31'b0, jump}, {31'b0, expJump});

            if (we && (dst != 5'd0)) begin
                regs[dst] = val;
            end
            for (int k = 0; k < 4; k++) begin
                if (be[k]) begin
                    memCopy[addr[7:2]][8*k +: 8] = wd[8*k +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/executeCore_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module executeCore_asserts (
    input logic Clk,
    input logic rst,
    input logic memRead,
    input logic memWrite,
    input logic regWrite,
    input logic branch,
    input logic jump
);

    int assertFails;   // tally for the closing summary

    initial begin
        assertFails = 0;
    end

    // a load and a store never share a cycle
    memExclusive: assert property (@(posedge Clk) disable iff (rst) !(memRead && memWrite))
        else begin
            $error("memRead and memWrite high in the same cycle");
            assertFails++;
        end

    branchNoWrite: assert property (@(posedge Clk) disable iff (rst) branch |-> !regWrite)
        else begin
            $error("branch decoded with regWrite high");
            assertFails++;
        end

    jumpNoWrite: assert property (@(posedge Clk) disable iff (rst) jump |-> !regWrite)
        else begin
            $error("jump decoded with regWrite high");   // j has no link
            assertFails++;
        end

endmodule

`default_nettype wire

// ==== tests/executeCore_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module executeCore_tb;

    localparam int resetCycles = 10;

    logic        Clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] memReadData;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;
    logic [3:0]  memByteEn;
    logic        memRead;
    logic        memWrite;
    logic        regWrite;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    logic        branchTaken;
    logic        jump;
    logic        active;
    logic        expBranch;
    logic        expJump;
    int          errorCount;
    int          checkCount;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    logic [31:0] dataMem [64];   // word index is memAddr[7:2]
    logic [31:0] rowInstr [$];
    logic        rowBranch [$];
    logic        rowJump [$];

    executeCore dut_i (
        .Clk          (Clk),
        .rst          (rst),
        .instr        (instr),
        .memReadData  (memReadData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memByteEn    (memByteEn),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .regWrite     (regWrite),
        .wbReg        (wbReg),
        .wbData       (wbData),
        .branchTaken  (branchTaken),
        .jump         (jump)
    );

    executeCoreChecker monitorUnit (
        .Clk          (Clk),
        .active       (active),
        .instr        (instr),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memByteEn    (memByteEn),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .regWrite     (regWrite),
        .wbReg        (wbReg),
        .wbData       (wbData),
        .branchTaken  (branchTaken),
        .jump         (jump),
        .expBranch    (expBranch),
        .expJump      (expJump),
        .errorCount   (errorCount),
        .checkCount   (checkCount)
    );

    // controller outputs, sampled on the core clock
    bind executeCore executeCore_asserts assertUnit (
        .Clk      (Clk),
        .rst      (rst),
        .memRead  (memRead),
        .memWrite (memWrite),
        .regWrite (regWrite),
        .branch   (branch),
        .jump     (jump)
    );

    always #4 Clk = ~Clk;

    assign memReadData = dataMem[memAddr[7:2]];   // answers in the same cycle

    always @(posedge Clk) begin
        for (int k = 0; k < 4; k++) begin
            if (memByteEn[k]) begin
                dataMem[memAddr[7:2]][8*k +: 8] <= memWriteData[8*k +: 8];
            end
        end
    end

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd,
                                            input logic [4:0] sa);
        return {mipsPkg::opRType, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addRow(input logic [31:0] word, input logic br, input logic jp);
        rowInstr.push_back(word);
        rowBranch.push_back(br);
        rowJump.push_back(jp);
    endtask

    task automatic buildTable();
        addRow(encodeI(mipsPkg::opAddi, 5'd0, 5'd1, 16'd5), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opAddi, 5'd0, 5'd2, 16'hFFFD), 1'b0, 1'b0);   // -3
        addRow(encodeI(mipsPkg::opAddiu, 5'd0, 5'd3, 16'h0040), 1'b0, 1'b0);  // memory base
        addRow(encodeI(mipsPkg::opOri, 5'd0, 5'd4, 16'h8001), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opAndi, 5'd2, 5'd5, 16'hF0F0), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opXori, 5'd1, 5'd6, 16'hFFFF), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opLui, 5'd0, 5'd7, 16'h8000), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opSlti, 5'd2, 5'd8, 16'd1), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opSltiu, 5'd2, 5'd9, 16'd1), 1'b0, 1'b0);
        addRow(encodeR(mipsPkg::fnAdd, 5'd1, 5'd2, 5'd10, 5'd0), 1'b0, 1'b0);
        addRow(encodeR(mipsPkg::fnSub, 5'd1, 5'd2, 5'd11, 5'd0), 1'b0, 1'b0);
        addRow(encodeR(mipsPkg::fnAnd, 5'd4, 5'd6, 5'd12, 5'd0), 1'b0, 1'b0);
        addRow(encodeR(mipsPkg::fnOr, 5'd4, 5'd6, 5'd13, 5'd0), 1'b0, 1'b0);
        addRow(encodeR(mipsPkg::fnXor, 5'd4, 5'd6, 5'd14, 5'd0), 1'b0, 1'b0);
        addRow(encodeR(mipsPkg::fnNor, 5'd1, 5'd2, 5'd15, 5'd0), 1'b0, 1'b0);
        addRow(encodeR(mipsPkg::fnSlt, 5'd2, 5'd1, 5'd16, 5'd0), 1'b0, 1'b0);
        addRow(encodeR(mipsPkg::fnSltu, 5'd2, 5'd1, 5'd17, 5'd0), 1'b0, 1'b0);
        addRow(encodeR(mipsPkg::fnSll, 5'd0, 5'd1, 5'd18, 5'd4), 1'b0, 1'b0);
        addRow(encodeR(mipsPkg::fnSrl, 5'd0, 5'd7, 5'd19, 5'd4), 1'b0, 1'b0);
        addRow(encodeR(mipsPkg::fnSrl, 5'd1, 5'd1, 5'd20, 5'd1), 1'b0, 1'b0);    // rotr
        addRow(encodeR(mipsPkg::fnSllv, 5'd1, 5'd1, 5'd21, 5'd0), 1'b0, 1'b0);
        addRow(encodeR(mipsPkg::fnSrlv, 5'd1, 5'd7, 5'd22, 5'd0), 1'b0, 1'b0);
        addRow(encodeR(mipsPkg::fnSrlv, 5'd1, 5'd4, 5'd23, 5'd1), 1'b0, 1'b0);   // rotrv
        addRow(encodeR(mipsPkg::fnAdd, 5'd1, 5'd1, 5'd0, 5'd0), 1'b0, 1'b0);     // to $zero
        addRow(encodeR(mipsPkg::fnAddu, 5'd0, 5'd1, 5'd24, 5'd0), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opSw, 5'd3, 5'd7, 16'd0), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opSh, 5'd3, 5'd4, 16'd6), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opSb, 5'd3, 5'd1, 16'd9), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opLw, 5'd3, 5'd25, 16'd0), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opLh, 5'd3, 5'd26, 16'd6), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opLb, 5'd3, 5'd27, 16'd9), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opLb, 5'd3, 5'd28, 16'd3), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opLh, 5'd3, 5'd29, 16'hFFFE), 1'b0, 1'b0);   // negative offset
        addRow(encodeI(mipsPkg::opLw, 5'd3, 5'd30, 16'd16), 1'b0, 1'b0);
        // seb and seh carry rd, sa and BSHFL in the low half
        addRow(encodeI(mipsPkg::opSpecial3, 5'd0, 5'd4, {5'd24, 5'b10000, 6'b100000}), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opSpecial3, 5'd0, 5'd4, {5'd25, 5'b11000, 6'b100000}), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opSpecial3, 5'd0, 5'd6, {5'd26, 5'b10000, 6'b100000}), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opBeq, 5'd1, 5'd1, 16'd4), 1'b1, 1'b0);
        addRow(encodeI(mipsPkg::opBeq, 5'd1, 5'd2, 16'd4), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opBne, 5'd1, 5'd2, 16'd4), 1'b1, 1'b0);
        addRow(encodeI(mipsPkg::opBne, 5'd1, 5'd1, 16'd4), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opRegImm, 5'd0, 5'd1, 16'd4), 1'b1, 1'b0);   // bgez zero
        addRow(encodeI(mipsPkg::opRegImm, 5'd2, 5'd1, 16'd4), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opRegImm, 5'd1, 5'd1, 16'd4), 1'b1, 1'b0);
        addRow(encodeI(mipsPkg::opRegImm, 5'd2, 5'd0, 16'd4), 1'b1, 1'b0);   // bltz negative
        addRow(encodeI(mipsPkg::opRegImm, 5'd0, 5'd0, 16'd4), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opRegImm, 5'd1, 5'd0, 16'd4), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opBgtz, 5'd1, 5'd0, 16'd4), 1'b1, 1'b0);
        addRow(encodeI(mipsPkg::opBgtz, 5'd0, 5'd0, 16'd4), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opBgtz, 5'd2, 5'd0, 16'd4), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opBlez, 5'd2, 5'd0, 16'd4), 1'b1, 1'b0);
        addRow(encodeI(mipsPkg::opBlez, 5'd0, 5'd0, 16'd4), 1'b1, 1'b0);
        addRow(encodeI(mipsPkg::opBlez, 5'd1, 5'd0, 16'd4), 1'b0, 1'b0);
        addRow(encodeI(mipsPkg::opJ, 5'd0, 5'd0, 16'h0100), 1'b0, 1'b1);
        addRow(encodeI(6'h3F, 5'd1, 5'd1, 16'h1234), 1'b0, 1'b0);   // unknown opcode
        addRow(encodeR(mipsPkg::fnAddu, 5'd1, 5'd0, 5'd27, 5'd0), 1'b0, 1'b0);
    endtask

    initial begin
        int seedValue;

        seedValue  = 32'h65d8d48b;
        dataMem[0] = $urandom(seedValue);   // seeds the generator once
        for (int i = 1; i < 64; i++) begin
            dataMem[i] = $urandom();
        end
        for (int i = 0; i < 64; i++) begin
            monitorUnit.memCopy[i] = dataMem[i];
        end
        Clk       = 1'b0;
        rst       = 1'b1;
        instr     = 32'b0;   // sll $0 keeps every control quiet
        active    = 1'b0;
        expBranch = 1'b0;
        expJump   = 1'b0;
        buildTable();
        cycleLimit = rowInstr.size() + resetCycles + 20;

        repeat (resetCycles) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;

        foreach (rowInstr[i]) begin
            instr     = rowInstr[i];
            expBranch = rowBranch[i];
            expJump   = rowJump[i];
            active    = 1'b1;
            @(negedge Clk);
        end
        active    = 1'b0;
        instr     = 32'b0;
        expBranch = 1'b0;
        expJump   = 1'b0;
        @(negedge Clk);

        $display("%0d checks, %0d errors, %0d assertion failures",
                 checkCount, errorCount, dut_i.assertUnit.assertFails);
        if ((errorCount == 0) && (dut_i.assertUnit.assertFails == 0)) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== executeCore.f ====
logic/mipsPkg.sv
logic/controller.sv
logic/aluUnit.sv
logic/registerFile.sv
logic/memAccess.sv
logic/executeCore.sv
tests/executeCoreChecker.sv
tests/executeCore_asserts.sv
tests/executeCore_tb.sv
